//--- sources.f
+incdir+testbench
verilog/mips_pkg.sv
verilog/mips_ifs.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/mips_top.sv
testbench/tb_mips.sv

//--- testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_word(input string what, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
    end
endtask

task automatic check_count(input string what, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, act);
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %b, got %b", $time, what, exp, act);
    end
endtask

task automatic abort_run(input string why);
    $display("Run stopped at %0t ns: %s", $time, why);
    $display("TEST FAIL");
    $finish;
endtask

// One Wishbone classic cycle starting 1 ns after a rising edge
task automatic wb_cycle(input logic we, input word_t adr, input word_t wdat,
                        output word_t rdat);
    int waited;
    waited   = 0;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do begin
        @(posedge i_clk);
        #1;
        waited++;
    end while (!o_wb_ack && waited < WB_TIMEOUT);
    if (!o_wb_ack) begin
        abort_run("the Wishbone port never raised ack");
    end else begin
        checks++;
        if (waited != 1) begin
            errors++;
            $display("Error at %0t ns: Wishbone ack came %0d cycles after stb instead of one",
                     $time, waited);
        end
        rdat     = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        @(posedge i_clk);
        #1;
        check_flag("ack one cycle wide", 1'b0, o_wb_ack);
    end
endtask

task automatic wb_write(input word_t adr, input word_t dat);
    word_t unused;
    wb_cycle(1'b1, adr, dat, unused);
endtask

task automatic wb_read(input word_t adr, output word_t dat);
    wb_cycle(1'b0, adr, '0, dat);
endtask

function automatic word_t make_r(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    instr_u u;
    u.r.opcode = R_TYPE;
    u.r.rs     = rs;
    u.r.rt     = rt;
    u.r.rd     = rd;
    u.r.shamt  = '0;
    u.r.funct  = fn;
    return u;
endfunction

function automatic word_t make_i(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                 logic [15:0] imm);
    instr_u u;
    u.i.opcode = op;
    u.i.rs     = rs;
    u.i.rt     = rt;
    u.i.imm    = imm;
    return u;
endfunction

task automatic load_program(input word_t words[$]);
    for (int i = 0; i < words.size(); i++) begin
        wb_write(word_t'(i), words[i]);
    end
endtask

task automatic wait_halted();
    int cycles;
    cycles = 0;
    while (!o_halted && cycles < RUN_TIMEOUT) begin
        @(posedge i_clk);
        #1;
        cycles++;
    end
    if (!o_halted) begin
        abort_run("o_halted never rose");
    end
endtask

// Walk all registers through the debug port
task automatic check_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
        @(posedge i_clk);
        #1;
        i_dbg_reg_addr = reg_addr_t'(r);
        #2;
        check_word($sformatf("r%0d", r), exp_regs[r], o_dbg_reg_data);
    end
endtask

`endif

//--- testbench/tb_mips.sv
module tb_mips;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam int IMEM_DEPTH  = 256;
    localparam int WB_TIMEOUT  = 20;
    localparam int RUN_TIMEOUT = 200;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_step;
    logic      i_wb_cyc;
    logic      i_wb_stb;
    logic      i_wb_we;
    word_t     i_wb_adr;
    word_t     i_wb_dat;
    word_t     o_wb_dat;
    logic      o_wb_ack;
    reg_addr_t i_dbg_reg_addr;
    word_t     o_dbg_reg_data;
    word_t     o_pc;
    logic      o_halted;
    word_t     o_retired;

    int    errors;
    int    checks;
    word_t exp_regs [NUM_REGS];
    word_t chain_regs [NUM_REGS];
    word_t prog [$];
    word_t chain_prog [$];

    mips_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) dut0 (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_step         (i_step),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_pc           (o_pc),
        .o_halted       (o_halted),
        .o_retired      (o_retired)
    );

    `include "tb_tasks.svh"

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic apply_reset();
        @(posedge i_clk);
        #1;
        i_step  = 1'b0;
        i_rst_n = 1'b0;
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        for (int r = 0; r < NUM_REGS; r++) begin
            exp_regs[r] = '0;
        end
    endtask

    // HALT at index halt_idx: pc ends two past it, everything before it retires
    task automatic run_to_halt(input int halt_idx);
        word_t pc_end;
        i_step = 1'b1;
        wait_halted();
        check_count("retired at halt", word_t'(halt_idx), o_retired);
        check_word("pc at halt", word_t'(halt_idx + 2), o_pc);
        pc_end = o_pc;
        repeat (10) begin
            @(posedge i_clk);
            #1;
        end
        check_word("pc after halt", pc_end, o_pc);
        check_count("retired after halt", word_t'(halt_idx), o_retired);
        check_flag("halted stays set", 1'b1, o_halted);
        check_regs();
    endtask

    task automatic test_bus();
        word_t data [16];
        word_t rd;
        for (int i = 0; i < 16; i++) begin
            data[i] = $urandom;
            wb_write(word_t'(i * 16 + 3), data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(word_t'(i * 16 + 3), rd);
            check_word($sformatf("imem[%0d]", i * 16 + 3), data[i], rd);
        end
    endtask

    task automatic test_immediates();
        logic [15:0] imm_or;
        logic [15:0] imm_add;
        logic [15:0] imm_lui;
        logic [15:0] imm_dep;
        // High bits set so zero and sign extension differ
        imm_or  = 16'($urandom) | 16'h8000;
        imm_add = 16'($urandom) | 16'h8000;
        imm_lui = 16'($urandom);
        imm_dep = 16'($urandom);
        apply_reset();
        prog.delete();
        prog.push_back(make_i(ORI, 5'd1, 5'd0, imm_or));
        prog.push_back(make_i(ADDIU, 5'd2, 5'd0, imm_add));
        prog.push_back(make_i(LUI, 5'd3, 5'd0, imm_lui));
        prog.push_back(make_i(ADDIU, 5'd4, 5'd1, imm_dep));
        prog.push_back(make_i(HALT, 5'd0, 5'd0, 16'h0000));
        exp_regs[1] = {16'h0000, imm_or};
        exp_regs[2] = {{16{imm_add[15]}}, imm_add};
        exp_regs[3] = {imm_lui, 16'h0000};
        exp_regs[4] = exp_regs[1] + {{16{imm_dep[15]}}, imm_dep};
        load_program(prog);
        run_to_halt(4);
    endtask

    task automatic test_chain();
        logic [15:0] hi1;
        logic [15:0] lo1;
        logic [15:0] hi2;
        logic [15:0] lo2;
        hi1 = 16'($urandom);
        lo1 = 16'($urandom);
        hi2 = 16'($urandom);
        lo2 = 16'($urandom);
        apply_reset();
        chain_prog.delete();
        chain_prog.push_back(make_i(LUI, 5'd1, 5'd0, hi1));
        chain_prog.push_back(make_i(ORI, 5'd1, 5'd1, lo1));
        chain_prog.push_back(make_i(LUI, 5'd2, 5'd0, hi2));
        chain_prog.push_back(make_i(ORI, 5'd2, 5'd2, lo2));
        chain_prog.push_back(make_r(ADDU, 5'd3, 5'd1, 5'd2));
        chain_prog.push_back(make_r(SUBU, 5'd4, 5'd3, 5'd1));
        chain_prog.push_back(make_r(AND, 5'd5, 5'd4, 5'd2));
        chain_prog.push_back(make_r(OR, 5'd6, 5'd5, 5'd3));
        chain_prog.push_back(make_r(XOR, 5'd7, 5'd6, 5'd4));
        chain_prog.push_back(make_r(SLT, 5'd8, 5'd7, 5'd1));
        chain_prog.push_back(make_i(HALT, 5'd0, 5'd0, 16'h0000));
        exp_regs[1] = {hi1, lo1};
        exp_regs[2] = {hi2, lo2};
        exp_regs[3] = exp_regs[1] + exp_regs[2];
        exp_regs[4] = exp_regs[3] - exp_regs[1];
        exp_regs[5] = exp_regs[4] & exp_regs[2];
        exp_regs[6] = exp_regs[5] | exp_regs[3];
        exp_regs[7] = exp_regs[6] ^ exp_regs[4];
        exp_regs[8] = ($signed(exp_regs[7]) < $signed(exp_regs[1])) ? 32'd1 : 32'd0;
        chain_regs = exp_regs;
        load_program(chain_prog);
        run_to_halt(10);
    endtask

    task automatic test_stall();
        word_t pc_hold;
        word_t ret_hold;
        apply_reset();
        exp_regs = chain_regs;
        load_program(chain_prog);
        i_step = 1'b1;
        repeat (6) begin
            @(posedge i_clk);
            #1;
        end
        i_step = 1'b0;
        // Six fetches, three entries out of the result stage
        check_word("pc after six steps", 32'd6, o_pc);
        check_count("retired after six steps", 32'd3, o_retired);
        pc_hold  = o_pc;
        ret_hold = o_retired;
        repeat (25) begin
            @(posedge i_clk);
            #1;
            check_word("pc while stalled", pc_hold, o_pc);
            check_count("retired while stalled", ret_hold, o_retired);
        end
        run_to_halt(10);
    endtask

    task automatic test_reg_zero();
        apply_reset();
        prog.delete();
        prog.push_back(make_i(ORI, 5'd5, 5'd0, 16'h55aa));
        prog.push_back(make_i(ADDIU, 5'd0, 5'd0, 16'h1234));
        prog.push_back(make_i(ORI, 5'd0, 5'd5, 16'hffff));
        prog.push_back(make_r(ADDU, 5'd9, 5'd0, 5'd5));
        // Opcode 3Eh and funct 20h are outside the subset
        prog.push_back({6'h3e, 5'd5, 5'd5, 16'hbeef});
        prog.push_back({6'h00, 5'd9, 5'd9, 5'd5, 5'd0, 6'h20});
        prog.push_back(make_i(XORI, 5'd11, 5'd5, 16'h00ff));
        prog.push_back(make_i(HALT, 5'd0, 5'd0, 16'h0000));
        exp_regs[5]  = 32'h0000_55aa;
        exp_regs[9]  = 32'h0000_55aa;
        exp_regs[11] = 32'h0000_5555;
        load_program(prog);
        run_to_halt(7);
    endtask

    task automatic test_halt();
        word_t rd;
        apply_reset();
        prog.delete();
        prog.push_back(make_i(ADDIU, 5'd1, 5'd0, 16'h0001));
        prog.push_back(make_i(ADDIU, 5'd2, 5'd1, 16'h0002));
        prog.push_back(make_r(ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(make_i(HALT, 5'd0, 5'd0, 16'h0000));
        // Words past HALT never reach the register file
        prog.push_back(make_i(ORI, 5'd10, 5'd0, 16'hffff));
        prog.push_back(make_i(ORI, 5'd11, 5'd0, 16'h1234));
        exp_regs[1] = 32'd1;
        exp_regs[2] = 32'd3;
        exp_regs[3] = 32'd4;
        load_program(prog);
        run_to_halt(3);
        wb_read(32'd3, rd);
        check_word("HALT word read with step high", 32'hfc00_0000, rd);
    endtask

    initial begin
        errors         = 0;
        checks         = 0;
        i_rst_n        = 1'b0;
        i_step         = 1'b0;
        i_wb_cyc       = 1'b0;
        i_wb_stb       = 1'b0;
        i_wb_we        = 1'b0;
        i_wb_adr       = '0;
        i_wb_dat       = '0;
        i_dbg_reg_addr = '0;
        void'($urandom(32'hac12_c581));
        apply_reset();
        test_bus();
        test_immediates();
        test_chain();
        test_stall();
        test_reg_zero();
        test_halt();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/mips_top.sv
module mips_top #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_step,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  mips_pkg::word_t     i_wb_adr,
    input  mips_pkg::word_t     i_wb_dat,
    output mips_pkg::word_t     o_wb_dat,
    output logic                o_wb_ack,
    input  mips_pkg::reg_addr_t i_dbg_reg_addr,
    output mips_pkg::word_t     o_dbg_reg_data,
    output mips_pkg::word_t     o_pc,
    output logic                o_halted,
    output mips_pkg::word_t     o_retired
);
    import mips_pkg::*;

    word_t     fetch_instr;
    logic      halt_req;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // Execute to result stage
    logic      ex_valid;
    logic      ex_wr_en;
    reg_addr_t ex_dest;
    word_t     ex_data;
    logic      ex_halt;

    decode_ex_if dx_bus ();
    wb_if        wb_bus ();

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_step     (i_step),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .i_halt_req (halt_req),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_pc       (o_pc),
        .o_instr    (fetch_instr)
    );

    decode_stage u_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_step    (i_step),
        .i_instr   (fetch_instr),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_rs_addr (rs_addr),
        .o_rt_addr (rt_addr),
        .o_dx      (dx_bus.sender)
    );

    reg_file u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs_addr  (rs_addr),
        .i_rt_addr  (rt_addr),
        .i_dbg_addr (i_dbg_reg_addr),
        .i_wr       (wb_bus.receiver),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_reg_data)
    );

    execute_stage u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_step     (i_step),
        .i_dx       (dx_bus.receiver),
        .i_fwd      (wb_bus.fwd),
        .o_halt_req (halt_req),
        .o_valid    (ex_valid),
        .o_wr_en    (ex_wr_en),
        .o_dest     (ex_dest),
        .o_data     (ex_data),
        .o_halt     (ex_halt)
    );

    result_stage u_result (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_step    (i_step),
        .i_valid   (ex_valid),
        .i_wr_en   (ex_wr_en),
        .i_dest    (ex_dest),
        .i_data    (ex_data),
        .i_halt    (ex_halt),
        .o_wb      (wb_bus.sender),
        .o_halted  (o_halted),
        .o_retired (o_retired)
    );

endmodule

//--- verilog/result_stage.sv
module result_stage (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_step,
    input  logic                i_valid,
    input  logic                i_wr_en,
    input  mips_pkg::reg_addr_t i_dest,
    input  mips_pkg::word_t     i_data,
    input  logic                i_halt,
    wb_if.sender                o_wb,
    output logic                o_halted,
    output mips_pkg::word_t     o_retired
);
    import mips_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
            o_wb.wr_en <= 1'b0;
            o_wb.dest  <= '0;
            o_wb.data  <= '0;
            o_wb.halt  <= 1'b0;
            o_halted   <= 1'b0;
            o_retired  <= '0;
        end else if (i_step && !o_halted) begin
            o_wb.valid <= i_valid;
            o_wb.wr_en <= i_valid && i_wr_en;
            o_wb.dest  <= i_dest;
            o_wb.data  <= i_data;
            o_wb.halt  <= i_valid && i_halt;
            if (i_valid && i_halt) begin
                o_halted <= 1'b1;
            end
            // Current entry leaves on this step
            if (o_wb.valid && !o_wb.halt) begin
                o_retired <= o_retired + 1'b1;
            end
        end
    end

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_step,
    decode_ex_if.receiver       i_dx,
    wb_if.fwd                   i_fwd,
    output logic                o_halt_req,
    output logic                o_valid,
    output logic                o_wr_en,
    output mips_pkg::reg_addr_t o_dest,
    output mips_pkg::word_t     o_data,
    output logic                o_halt
);
    import mips_pkg::*;

    logic  halt_seen;
    logic  live;
    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_y;

    // Result stage entry wins over the value read in decode
    function automatic word_t fwd_operand(input reg_addr_t src, input word_t reg_val);
        if (src != '0 && i_fwd.valid && i_fwd.wr_en && i_fwd.dest == src) begin
            return i_fwd.data;
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a     = fwd_operand(i_dx.rs, i_dx.rs_data);
        op_b_reg = fwd_operand(i_dx.rt, i_dx.rt_data);
        op_b     = i_dx.use_imm ? i_dx.imm : op_b_reg;
    end

    always_comb begin
        case (i_dx.alu_op)
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halt_seen <= 1'b0;
        end else if (i_step && i_dx.valid && i_dx.halt) begin
            halt_seen <= 1'b1;
        end
    end

    // Anything decoded after HALT is dropped here
    assign live       = i_dx.valid && !halt_seen;
    assign o_halt_req = halt_seen || (i_dx.valid && i_dx.halt);
    assign o_valid    = live;
    assign o_wr_en    = live && i_dx.wr_en;
    assign o_dest     = i_dx.dest;
    assign o_data     = alu_y;
    assign o_halt     = live && i_dx.halt;

    halt_req_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_halt_req |=> o_halt_req);

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_step,
    input  mips_pkg::word_t     i_instr,
    input  mips_pkg::word_t     i_rs_data,
    input  mips_pkg::word_t     i_rt_data,
    output mips_pkg::reg_addr_t o_rs_addr,
    output mips_pkg::reg_addr_t o_rt_addr,
    decode_ex_if.sender         o_dx
);
    import mips_pkg::*;

    instr_u    ir;
    alu_op_e   alu_op;
    ext_mode_e ext_mode;
    logic      use_imm;
    logic      wr_en;
    logic      halt;
    reg_addr_t dest;
    word_t     imm_ext;

    assign ir        = i_instr;
    assign o_rs_addr = ir.r.rs;
    assign o_rt_addr = ir.r.rt;

    // Control decode, defaults give an I-type with no write
    always_comb begin
        alu_op   = ALU_ADD;
        ext_mode = EXT_SIGN;
        use_imm  = 1'b1;
        wr_en    = 1'b0;
        halt     = 1'b0;
        dest     = ir.i.rt;
        case (ir.i.opcode)
            R_TYPE: begin
                use_imm = 1'b0;
                dest    = ir.r.rd;
                wr_en   = 1'b1;
                case (ir.r.funct)
                    ADDU:    alu_op = ALU_ADD;
                    SUBU:    alu_op = ALU_SUB;
                    AND:     alu_op = ALU_AND;
                    OR:      alu_op = ALU_OR;
                    XOR:     alu_op = ALU_XOR;
                    SLT:     alu_op = ALU_SLT;
                    default: wr_en  = 1'b0;
                endcase
            end
            ADDIU: wr_en = 1'b1;
            SLTI: begin
                alu_op = ALU_SLT;
                wr_en  = 1'b1;
            end
            ANDI: begin
                alu_op   = ALU_AND;
                ext_mode = EXT_ZERO;
                wr_en    = 1'b1;
            end
            ORI: begin
                alu_op   = ALU_OR;
                ext_mode = EXT_ZERO;
                wr_en    = 1'b1;
            end
            XORI: begin
                alu_op   = ALU_XOR;
                ext_mode = EXT_ZERO;
                wr_en    = 1'b1;
            end
            LUI: begin
                alu_op   = ALU_PASS_B;
                ext_mode = EXT_UPPER;
                wr_en    = 1'b1;
            end
            HALT:    halt = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (ext_mode)
            EXT_ZERO:  imm_ext = {16'h0000, ir.i.imm};
            EXT_UPPER: imm_ext = {ir.i.imm, 16'h0000};
            default:   imm_ext = {{16{ir.i.imm[15]}}, ir.i.imm};
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dx.valid   <= 1'b0;
            o_dx.rs      <= '0;
            o_dx.rt      <= '0;
            o_dx.rs_data <= '0;
            o_dx.rt_data <= '0;
            o_dx.imm     <= '0;
            o_dx.use_imm <= 1'b0;
            o_dx.alu_op  <= ALU_ADD;
            o_dx.dest    <= '0;
            o_dx.wr_en   <= 1'b0;
            o_dx.halt    <= 1'b0;
        end else if (i_step) begin
            // Bubbles from reset or behind HALT carry no valid
            o_dx.valid   <= (i_instr != NOP_WORD);
            o_dx.rs      <= ir.r.rs;
            o_dx.rt      <= ir.r.rt;
            o_dx.rs_data <= i_rs_data;
            o_dx.rt_data <= i_rt_data;
            o_dx.imm     <= imm_ext;
            o_dx.use_imm <= use_imm;
            o_dx.alu_op  <= alu_op;
            o_dx.dest    <= dest;
            o_dx.wr_en   <= wr_en;
            o_dx.halt    <= halt;
        end
    end

endmodule

//--- verilog/reg_file.sv
module reg_file (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  mips_pkg::reg_addr_t i_rs_addr,
    input  mips_pkg::reg_addr_t i_rt_addr,
    input  mips_pkg::reg_addr_t i_dbg_addr,
    wb_if.receiver              i_wr,
    output mips_pkg::word_t     o_rs_data,
    output mips_pkg::word_t     o_rt_data,
    output mips_pkg::word_t     o_dbg_data
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_live;

    assign wr_live = i_wr.valid && i_wr.wr_en && (i_wr.dest != '0);

    // Write-first read
    function automatic word_t read_reg(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_live && i_wr.dest == addr) begin
            return i_wr.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_wr.dest] <= i_wr.data;
        end
    end

    always_comb begin
        o_rs_data  = read_reg(i_rs_addr);
        o_rt_data  = read_reg(i_rt_addr);
        o_dbg_data = read_reg(i_dbg_addr);
    end

    r0_stays_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr.valid && i_wr.wr_en && i_wr.dest == '0) |=> (regs[0] == '0));

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_step,
    input  logic            i_wb_cyc,
    input  logic            i_wb_stb,
    input  logic            i_wb_we,
    input  mips_pkg::word_t i_wb_adr,
    input  mips_pkg::word_t i_wb_dat,
    input  logic            i_halt_req,
    output mips_pkg::word_t o_wb_dat,
    output logic            o_wb_ack,
    output mips_pkg::word_t o_pc,
    output mips_pkg::word_t o_instr
);
    import mips_pkg::*;

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    word_t             imem [IMEM_DEPTH];
    logic              wb_req;
    logic [ADDR_W-1:0] wb_idx;

    // New request only when no ack is pending
    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wb_idx = i_wb_adr[ADDR_W-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wb_req) begin
            if (i_wb_we) begin
                imem[wb_idx] <= i_wb_dat;
            end
            o_wb_dat <= imem[wb_idx];
        end
    end

    // PC and fetch register, frozen behind a HALT
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc    <= '0;
            o_instr <= NOP_WORD;
        end else if (i_step) begin
            if (i_halt_req) begin
                o_instr <= NOP_WORD;
            end else begin
                o_instr <= imem[o_pc[ADDR_W-1:0]];
                o_pc    <= o_pc + 1'b1;
            end
        end
    end

    ack_needs_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb));

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack);

endmodule

//--- verilog/mips_ifs.sv
// Decode to execute pipeline register contents
interface decode_ex_if;
    import mips_pkg::*;

    logic      valid;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    reg_addr_t dest;
    logic      wr_en;
    logic      halt;

    modport sender (
        output valid, rs, rt, rs_data, rt_data, imm, use_imm, alu_op, dest, wr_en, halt
    );

    modport receiver (
        input valid, rs, rt, rs_data, rt_data, imm, use_imm, alu_op, dest, wr_en, halt
    );

endinterface

// Write-back entry, also the forwarding source
interface wb_if;
    import mips_pkg::*;

    logic      valid;
    logic      wr_en;
    reg_addr_t dest;
    word_t     data;
    logic      halt;

    modport sender   (output valid, wr_en, dest, data, halt);
    modport fwd      (input valid, wr_en, dest, data);
    modport receiver (input valid, wr_en, dest, data);

endinterface

//--- verilog/mips_pkg.sv
package mips_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        ADDIU  = 6'h09,
        SLTI   = 6'h0A,
        ANDI   = 6'h0C,
        ORI    = 6'h0D,
        XORI   = 6'h0E,
        LUI    = 6'h0F,
        HALT   = 6'h3F
    } opcode_e;

    typedef enum logic [5:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // EXT_UPPER puts the immediate in bits 31:16
    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO,
        EXT_UPPER
    } ext_mode_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_e    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // One instruction word, R or I view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    localparam word_t NOP_WORD = '0;

endpackage
